/* common/bp_pkg.sv */
package bp_pkg;

	//////////////////////////////////////////////////////////////////////
	// address and table geometry
	//////////////////////////////////////////////////////////////////////

	// pc values are word addresses
	localparam int PC_W     = 10;
	// set index comes from the low pc bits
	localparam int SET_W    = 4;
	localparam int WAY_W    = 2;
	localparam int NUM_SETS = 1 << SET_W;
	localparam int NUM_WAYS = 1 << WAY_W;
	localparam int ENTRIES  = NUM_SETS * NUM_WAYS;
	// isr bit on top of pc[9:4]
	localparam int TAG_W    = 7;

	// entry layout {valid, tag, target, counter}
	localparam int ENTRY_W   = 20;
	localparam int VALID_BIT = 19;
	localparam int TAG_HI    = 18;
	localparam int TAG_LO    = 12;
	localparam int TGT_HI    = 11;
	localparam int TGT_LO    = 2;
	localparam int CTR_HI    = 1;
	localparam int CTR_LO    = 0;

	//////////////////////////////////////////////////////////////////////
	// saturating counter
	//////////////////////////////////////////////////////////////////////

	localparam int CTR_W = 2;
	localparam logic [CTR_W-1:0] CTR_MIN       = 2'd0;
	localparam logic [CTR_W-1:0] CTR_MAX       = 2'd3;
	// jumps start strongly taken, branches weakly not taken
	localparam logic [CTR_W-1:0] CTR_INIT_JUMP = 2'd3;
	localparam logic [CTR_W-1:0] CTR_INIT_BR   = 2'd1;

	//////////////////////////////////////////////////////////////////////
	// branch type and correction codes
	//////////////////////////////////////////////////////////////////////

	// one-hot branch type from decode
	localparam int BTYPE_W = 6;
	localparam int BT_BEQ  = 5;
	localparam int BT_BNE  = 4;
	localparam int BT_BLT  = 3;
	localparam int BT_BGE  = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	localparam int CORR_W = 2;
	localparam logic [CORR_W-1:0] CORR_NONE = 2'd0;
	// refetch the instruction after the branch
	localparam logic [CORR_W-1:0] CORR_CNI  = 2'd2;
	// refetch at the stored branch target
	localparam logic [CORR_W-1:0] CORR_PBT  = 2'd3;

endpackage

/* predictor/bht_table.sv */
module bht_table import bp_pkg::*; (
	input  logic              CLK,
	input  logic              nrst,
	input  logic              en,
	input  logic              stall,
	input  logic              isr_running,
	input  logic [PC_W-1:0]   if_pc,
	input  logic [PC_W-1:0]   id_pc,
	input  logic [PC_W-1:0]   id_branch_target,
	input  logic              id_is_jump,
	input  logic              id_is_btype,
	input  logic [PC_W-1:0]   exe_pc,
	input  logic              exe_resolve,
	input  logic              exe_taken,
	output logic              if_hit_taken,
	output logic [PC_W-1:0]   if_pbt,
	output logic              id_hit,
	output logic              exe_ctr_taken,
	output logic [PC_W-1:0]   exe_pbt
);

	// history array, word index is {set, way}
	logic [ENTRIES-1:0][ENTRY_W-1:0] ht;
	// per set pointer to the next way to replace
	logic [NUM_SETS-1:0][WAY_W-1:0] fifo_ptr;

	//////////////////////////////////////////////////////////////////////
	// lookups, index 0 fetch, 1 decode, 2 execute
	//////////////////////////////////////////////////////////////////////

	logic [2:0][PC_W-1:0]     lk_pc;
	logic [2:0][SET_W-1:0]    lk_set;
	logic [2:0][TAG_W-1:0]    lk_tag;
	logic [2:0][NUM_WAYS-1:0] lk_hit;
	logic [2:0][WAY_W-1:0]    lk_way;
	logic [2:0][ENTRY_W-1:0]  lk_ent;

	assign lk_pc = {exe_pc, id_pc, if_pc};

	always_comb begin
		for (int s = 0; s < 3; s++) begin
			lk_set[s] = lk_pc[s][SET_W-1:0];
			// isr code gets its own tag space
			lk_tag[s] = {isr_running, lk_pc[s][PC_W-1:SET_W]};
			lk_hit[s] = '0;
			lk_way[s] = '0;
			// a miss reads as all zero
			lk_ent[s] = '0;
			for (int w = 0; w < NUM_WAYS; w++) begin
				if (ht[{lk_set[s], WAY_W'(w)}][VALID_BIT] &&
						ht[{lk_set[s], WAY_W'(w)}][TAG_HI:TAG_LO] == lk_tag[s]) begin
					lk_hit[s][w] = 1'b1;
					lk_way[s]    = WAY_W'(w);
					lk_ent[s]    = ht[{lk_set[s], WAY_W'(w)}];
				end
			end
		end
	end

	// fetch side prediction
	assign if_hit_taken  = lk_ent[0][CTR_HI];
	assign if_pbt        = lk_ent[0][TGT_HI:TGT_LO];
	// decode only needs presence
	assign id_hit        = |lk_hit[1];
	// execute side, counter msb is the stored prediction
	assign exe_ctr_taken = lk_ent[2][CTR_HI];
	assign exe_pbt       = lk_ent[2][TGT_HI:TGT_LO];

	//////////////////////////////////////////////////////////////////////
	// allocation and training
	//////////////////////////////////////////////////////////////////////

	logic             alloc;
	logic             train;
	logic [CTR_W-1:0] ctr_init;
	logic [CTR_W-1:0] ctr_cur;
	logic [CTR_W-1:0] ctr_next;

	// new branch or jump seen at decode
	assign alloc    = (id_is_jump || id_is_btype) && !id_hit;
	// only a resolved branch that is in the table trains
	assign train    = exe_resolve && |lk_hit[2];
	assign ctr_init = id_is_jump ? CTR_INIT_JUMP : CTR_INIT_BR;
	assign ctr_cur  = lk_ent[2][CTR_HI:CTR_LO];

	// saturating step toward the outcome
	always_comb begin
		if (exe_taken)
			ctr_next = (ctr_cur == CTR_MAX) ? ctr_cur : ctr_cur + CTR_W'(1);
		else
			ctr_next = (ctr_cur == CTR_MIN) ? ctr_cur : ctr_cur - CTR_W'(1);
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			ht       <= '0;
			fifo_ptr <= '0;
		end else if (en && !stall) begin
			if (alloc) begin
				// oldest way in the set is overwritten
				ht[{lk_set[1], fifo_ptr[lk_set[1]]}] <=
					{1'b1, lk_tag[1], id_branch_target, ctr_init};
				fifo_ptr[lk_set[1]] <= fifo_ptr[lk_set[1]] + WAY_W'(1);
			end else if (train) begin
				// training in an allocation cycle is dropped
				ht[{lk_set[2], lk_way[2]}][CTR_HI:CTR_LO] <= ctr_next;
			end
		end
	end

	// allocation only happens on a decode miss, so a tag never lands twice in a set
	a_single_hit: assert property (@(posedge CLK) disable iff (!nrst)
		$onehot0(lk_hit[0]) && $onehot0(lk_hit[1]) && $onehot0(lk_hit[2]))
		else $error("more than one way hit in a lookup");

	// a stalled cycle leaves the table and pointers untouched
	a_stall_freeze: assert property (@(posedge CLK) disable iff (!nrst)
		stall |=> $stable(ht) && $stable(fifo_ptr))
		else $error("table written during stall");

endmodule

/* predictor/branch_resolve.sv */
module branch_resolve import bp_pkg::*; (
	input  logic [BTYPE_W-1:0] exe_btype,
	input  logic               exe_z,
	input  logic               exe_less,
	input  logic               exe_ctr_taken,
	output logic               exe_resolve,
	output logic               exe_taken,
	output logic [CORR_W-1:0]  exe_correction
);

	logic cond_eq;
	logic cond_lt;
	logic mismatch;

	//////////////////////////////////////////////////////////////////////
	// condition evaluation from alu flags
	//////////////////////////////////////////////////////////////////////

	// beq and bne look at zero
	assign cond_eq = (exe_btype[BT_BEQ] && exe_z) ||
	                 (exe_btype[BT_BNE] && !exe_z);

	// signed and unsigned compares share the less flag,
	// the alu already picked the right comparison
	assign cond_lt = ((exe_btype[BT_BLT] || exe_btype[BT_BLTU]) && exe_less) ||
	                 ((exe_btype[BT_BGE] || exe_btype[BT_BGEU]) && !exe_less);

	assign exe_taken   = cond_eq || cond_lt;
	// any type bit means a conditional branch sits in execute
	assign exe_resolve = |exe_btype;

	//////////////////////////////////////////////////////////////////////
	// correction against the stored prediction
	//////////////////////////////////////////////////////////////////////

	assign mismatch = exe_resolve && (exe_taken != exe_ctr_taken);

	always_comb begin
		if (!mismatch)
			exe_correction = CORR_NONE;
		else if (exe_taken)
			// predicted not taken, go to the target
			exe_correction = CORR_PBT;
		else
			// predicted taken, fall through
			exe_correction = CORR_CNI;
	end

	// decode hands over at most one branch type
	a_btype_onehot: assert final ($onehot0(exe_btype))
		else $error("exe_btype is not one-hot");

endmodule

/* predictor/flush_ctrl.sv */
module flush_ctrl import bp_pkg::*; (
	input  logic              CLK,
	input  logic              nrst,
	input  logic              en,
	input  logic [CORR_W-1:0] exe_correction,
	input  logic              id_is_jump,
	input  logic              id_hit,
	output logic              flush,
	output logic              id_jump_in_bht
);

	logic mispredict;
	// one pending flush cycle
	logic flush_state;
	logic flush_state_d;

	assign mispredict = (exe_correction != CORR_NONE);

	always_comb begin
		if (flush_state) begin
			// pending cycle wins and consumes the state
			flush         = 1'b1;
			flush_state_d = 1'b0;
		end else if (mispredict) begin
			flush         = 1'b1;
			flush_state_d = 1'b1;
		end else begin
			flush         = 1'b0;
			// new jump gets a flush once its target is in the table
			flush_state_d = id_is_jump && !id_hit;
		end
	end

	// advances with en only, stall does not hold it
	always_ff @(posedge CLK) begin
		if (!nrst)
			flush_state <= 1'b0;
		else if (en)
			flush_state <= flush_state_d;
	end

	assign id_jump_in_bht = id_is_jump && id_hit;

	// an extension cycle never chains into a third flush on its own
	a_flush_len: assert property (@(posedge CLK) disable iff (!nrst)
		(en && flush_state) |=> (!flush || mispredict))
		else $error("flush held past its extension cycle");

endmodule

/* verilog/next_pc_sel.sv */
module next_pc_sel import bp_pkg::*; (
	input  logic              CLK,
	input  logic              nrst,
	input  logic              en,
	input  logic              stall,
	input  logic [PC_W-1:0]   exe_pc,
	input  logic [CORR_W-1:0] exe_correction,
	input  logic [PC_W-1:0]   exe_pbt,
	input  logic              if_hit_taken,
	input  logic [PC_W-1:0]   if_pbt,
	output logic [PC_W-1:0]   if_pc
);

	logic [PC_W-1:0] pc_next;

	//////////////////////////////////////////////////////////////////////
	// next pc priority
	//////////////////////////////////////////////////////////////////////

	// execute corrections override the fetch prediction
	always_comb begin
		if (exe_correction == CORR_PBT)
			pc_next = exe_pbt;
		else if (exe_correction == CORR_CNI)
			pc_next = exe_pc + PC_W'(1);
		else if (if_hit_taken)
			pc_next = if_pbt;
		else
			// word addresses step by one
			pc_next = if_pc + PC_W'(1);
	end

	// fetch pc register
	always_ff @(posedge CLK) begin
		if (!nrst)
			if_pc <= '0;
		else if (en && !stall)
			if_pc <= pc_next;
	end

endmodule

/* verilog/branch_unit_top.sv */
module branch_unit_top import bp_pkg::*; (
	input  logic               CLK,
	input  logic               nrst,
	input  logic               en,
	input  logic               stall,
	input  logic               isr_running,
	input  logic [PC_W-1:0]    id_pc,
	input  logic [PC_W-1:0]    id_branch_target,
	input  logic               id_is_jump,
	input  logic               id_is_btype,
	input  logic [PC_W-1:0]    exe_pc,
	input  logic               exe_z,
	input  logic               exe_less,
	input  logic [BTYPE_W-1:0] exe_btype,
	output logic [PC_W-1:0]    if_pc,
	output logic               flush,
	output logic               id_jump_in_bht,
	output logic [CORR_W-1:0]  exe_correction
);

	// fetch lookup results
	logic            if_hit_taken;
	logic [PC_W-1:0] if_pbt;
	// decode presence
	logic            id_hit;
	// execute lookup and resolution
	logic            exe_ctr_taken;
	logic [PC_W-1:0] exe_pbt;
	logic            exe_resolve;
	logic            exe_taken;

	branch_resolve u_resolve (
		.exe_btype      (exe_btype),
		.exe_z          (exe_z),
		.exe_less       (exe_less),
		.exe_ctr_taken  (exe_ctr_taken),
		.exe_resolve    (exe_resolve),
		.exe_taken      (exe_taken),
		.exe_correction (exe_correction)
	);

	bht_table u_bht (
		.CLK              (CLK),
		.nrst             (nrst),
		.en               (en),
		.stall            (stall),
		.isr_running      (isr_running),
		.if_pc            (if_pc),
		.id_pc            (id_pc),
		.id_branch_target (id_branch_target),
		.id_is_jump       (id_is_jump),
		.id_is_btype      (id_is_btype),
		.exe_pc           (exe_pc),
		.exe_resolve      (exe_resolve),
		.exe_taken        (exe_taken),
		.if_hit_taken     (if_hit_taken),
		.if_pbt           (if_pbt),
		.id_hit           (id_hit),
		.exe_ctr_taken    (exe_ctr_taken),
		.exe_pbt          (exe_pbt)
	);

	next_pc_sel u_next_pc (
		.CLK            (CLK),
		.nrst           (nrst),
		.en             (en),
		.stall          (stall),
		.exe_pc         (exe_pc),
		.exe_correction (exe_correction),
		.exe_pbt        (exe_pbt),
		.if_hit_taken   (if_hit_taken),
		.if_pbt         (if_pbt),
		.if_pc          (if_pc)
	);

	flush_ctrl u_flush (
		.CLK            (CLK),
		.nrst           (nrst),
		.en             (en),
		.exe_correction (exe_correction),
		.id_is_jump     (id_is_jump),
		.id_hit         (id_hit),
		.flush          (flush),
		.id_jump_in_bht (id_jump_in_bht)
	);

endmodule

/* test/tb_clock.sv */
module tb_clock (
	output logic CLK,
	output logic nrst
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	localparam int HALF_PERIOD  = 4;
	localparam int RESET_CYCLES = 10;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// release reset just after an edge
	initial begin
		nrst = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 nrst = 1'b1;
	end

endmodule

/* test/tb_branch_unit.sv */
module tb_branch_unit import bp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// run bound of about four times the test length
	localparam int MAX_CYCLES  = 2000;
	localparam int RAND_ROUNDS = 400;

	logic               CLK;
	logic               nrst;
	logic               en;
	logic               stall;
	logic               isr_running;
	logic [PC_W-1:0]    id_pc;
	logic [PC_W-1:0]    id_branch_target;
	logic               id_is_jump;
	logic               id_is_btype;
	logic [PC_W-1:0]    exe_pc;
	logic               exe_z;
	logic               exe_less;
	logic [BTYPE_W-1:0] exe_btype;
	logic [PC_W-1:0]    if_pc;
	logic               flush;
	logic               id_jump_in_bht;
	logic [CORR_W-1:0]  exe_correction;

	//////////////////////////////////////////////////////////////////////
	// reference model state
	//////////////////////////////////////////////////////////////////////

	// entry index is set * NUM_WAYS + way
	logic               m_valid [ENTRIES];
	logic [TAG_W-1:0]   m_tag [ENTRIES];
	logic [PC_W-1:0]    m_tgt [ENTRIES];
	logic [CTR_W-1:0]   m_ctr [ENTRIES];
	logic [WAY_W-1:0]   m_ptr [NUM_SETS];
	// one pending flush cycle
	logic               m_fstate;
	logic [PC_W-1:0]    exp_pc;
	// outputs sampled in the last cycle
	logic               seen_flush;
	logic               seen_jib;
	logic [CORR_W-1:0]  seen_corr;

	integer seed = 34;
	int     errors = 0;
	int     tests = 0;
	int     failed = 0;
	int     errs_start = 0;
	int     cycles = 0;
	string  cur_test;

	tb_clock u_clock (.CLK(CLK), .nrst(nrst));

	branch_unit_top dut (.*);

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks and reporting
	//////////////////////////////////////////////////////////////////////

	task automatic compare_pc(logic [PC_W-1:0] exp_v, logic [PC_W-1:0] act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("Fail %s: if_pc expected %0d actual %0d", cur_test, exp_v, act_v);
		end
	endtask

	task automatic compare_corr(logic [CORR_W-1:0] exp_v, logic [CORR_W-1:0] act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("Fail %s: exe_correction expected %0d actual %0d",
				cur_test, exp_v, act_v);
		end
	endtask

	task automatic compare_bit(string what, logic exp_v, logic act_v);
		if (act_v !== exp_v) begin
			errors++;
			$display("Fail %s: %s expected %0b actual %0b", cur_test, what, exp_v, act_v);
		end
	endtask

	task automatic note_error(string msg);
		errors++;
		$display("Error in %s: %s", cur_test, msg);
	endtask

	task automatic start_test(string name);
		cur_test   = name;
		errs_start = errors;
	endtask

	task automatic finish_test();
		tests++;
		if (errors == errs_start) begin
			$display("test %s ok", cur_test);
		end else begin
			failed++;
			$display("test %s: %0d errors", cur_test, errors - errs_start);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	// matching entry for a pc under the current isr state or -1 on a miss
	function automatic int m_find(logic [PC_W-1:0] pc);
		int idx;
		m_find = -1;
		for (int w = 0; w < NUM_WAYS; w++) begin
			idx = int'(pc[SET_W-1:0]) * NUM_WAYS + w;
			if (m_valid[idx] && m_tag[idx] == {isr_running, pc[PC_W-1:SET_W]})
				m_find = idx;
		end
	endfunction

	// a miss reads as not taken with target zero
	function automatic logic m_pred(int idx);
		return (idx < 0) ? 1'b0 : m_ctr[idx][CTR_W-1];
	endfunction

	function automatic logic [PC_W-1:0] m_target(int idx);
		return (idx < 0) ? '0 : m_tgt[idx];
	endfunction

	// bits from msb are beq bne blt bge bltu bgeu
	function automatic logic cond_taken(logic [BTYPE_W-1:0] bt, logic z, logic less);
		case (bt)
			6'b100000: return z;
			6'b010000: return !z;
			6'b001000, 6'b000010: return less;
			6'b000100, 6'b000001: return !less;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [CORR_W-1:0] exp_corr();
		logic taken;
		taken = cond_taken(exe_btype, exe_z, exe_less);
		if (exe_btype == '0 || taken == m_pred(m_find(exe_pc)))
			return CORR_NONE;
		return taken ? CORR_PBT : CORR_CNI;
	endfunction

	// check outputs mid cycle and advance the model, then check if_pc after the edge
	task automatic step();
		logic [CORR_W-1:0] c;
		logic [PC_W-1:0]   pc_n;
		logic              taken;
		int                f;
		int                d;
		int                e;
		int                slot;
		#1;
		c     = exp_corr();
		f     = m_find(exp_pc);
		d     = m_find(id_pc);
		e     = m_find(exe_pc);
		taken = cond_taken(exe_btype, exe_z, exe_less);
		seen_flush = flush;
		seen_jib   = id_jump_in_bht;
		seen_corr  = exe_correction;
		compare_corr(c, exe_correction);
		compare_bit("flush", m_fstate || c != CORR_NONE, flush);
		compare_bit("id_jump_in_bht", id_is_jump && d >= 0, id_jump_in_bht);
		// execute corrections go before the fetch prediction
		if (c == CORR_PBT)
			pc_n = m_target(e);
		else if (c == CORR_CNI)
			pc_n = exe_pc + PC_W'(1);
		else if (m_pred(f))
			pc_n = m_target(f);
		else
			pc_n = exp_pc + PC_W'(1);
		if (en && !stall) begin
			exp_pc = pc_n;
			if ((id_is_jump || id_is_btype) && d < 0) begin
				// fifo victim in the decode set
				slot = int'(id_pc[SET_W-1:0]) * NUM_WAYS + int'(m_ptr[id_pc[SET_W-1:0]]);
				m_valid[slot] = 1'b1;
				m_tag[slot]   = {isr_running, id_pc[PC_W-1:SET_W]};
				m_tgt[slot]   = id_branch_target;
				m_ctr[slot]   = id_is_jump ? CTR_INIT_JUMP : CTR_INIT_BR;
				m_ptr[id_pc[SET_W-1:0]]++;
			end else if (exe_btype != '0 && e >= 0) begin
				if (taken && m_ctr[e] != 2'd3)
					m_ctr[e]++;
				else if (!taken && m_ctr[e] != 2'd0)
					m_ctr[e]--;
			end
		end
		// a pending cycle clears the state or else a mispredict or new jump sets it
		if (en)
			m_fstate = m_fstate ? 1'b0 : (c != CORR_NONE) || (id_is_jump && d < 0);
		@(posedge CLK);
		#1;
		compare_pc(exp_pc, if_pc);
	endtask

	task automatic resolve(logic [PC_W-1:0] pc, logic [BTYPE_W-1:0] bt, logic z, logic less);
		exe_pc    = pc;
		exe_btype = bt;
		exe_z     = z;
		exe_less  = less;
		step();
		exe_btype = '0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_seq_fetch();
		start_test("seq_fetch");
		compare_bit("flush after reset", 1'b0, flush);
		repeat (5) step();
		compare_pc(PC_W'(5), if_pc);
		stall = 1'b1;
		repeat (3) step();
		stall = 1'b0;
		compare_pc(PC_W'(5), if_pc);
		en = 1'b0;
		repeat (3) step();
		en = 1'b1;
		compare_pc(PC_W'(5), if_pc);
		repeat (2) step();
		finish_test();
	endtask

	task automatic test_jump();
		logic [PC_W-1:0] jpc;
		int              nflush;
		int              n;
		start_test("jump");
		// jump a few words ahead of fetch
		jpc              = exp_pc + PC_W'(4);
		id_pc            = jpc;
		id_branch_target = PC_W'(40);
		id_is_jump       = 1'b1;
		step();
		nflush     = seen_flush;
		id_is_jump = 1'b0;
		repeat (2) begin
			step();
			nflush += seen_flush;
		end
		if (nflush != 1)
			note_error($sformatf("new jump flushed for %0d cycles instead of one", nflush));
		id_is_jump = 1'b1;
		step();
		compare_bit("id_jump_in_bht", 1'b1, seen_jib);
		id_is_jump = 1'b0;
		n = 0;
		while (if_pc != jpc && n < 16) begin
			step();
			n++;
		end
		if (if_pc != jpc)
			note_error("fetch never reached the jump address");
		step();
		compare_pc(PC_W'(40), if_pc);
		finish_test();
	endtask

	task automatic test_branch_train();
		logic [PC_W-1:0]   bpc;
		logic [PC_W-1:0]   btgt;
		logic [CORR_W-1:0] want [5];
		logic              outcome [5];
		int                nflush;
		start_test("branch_train");
		bpc     = PC_W'(512);
		btgt    = PC_W'(300);
		// counter walks 1 2 3 2 1 0
		want    = '{CORR_PBT, CORR_NONE, CORR_CNI, CORR_CNI, CORR_NONE};
		outcome = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
		id_pc            = bpc;
		id_branch_target = btgt;
		id_is_btype      = 1'b1;
		step();
		id_is_btype = 1'b0;
		for (int i = 0; i < 5; i++) begin
			resolve(bpc, BTYPE_W'(1) << BT_BEQ, outcome[i], 1'b0);
			compare_corr(want[i], seen_corr);
			if (want[i] == CORR_PBT)
				compare_pc(btgt, if_pc);
			if (want[i] == CORR_CNI)
				compare_pc(bpc + PC_W'(1), if_pc);
			nflush = seen_flush;
			repeat (2) begin
				step();
				nflush += seen_flush;
			end
			if (nflush != ((want[i] == CORR_NONE) ? 0 : 2))
				note_error($sformatf("resolution %0d flushed for %0d cycles", i, nflush));
		end
		finish_test();
	endtask

	task automatic test_conditions();
		int pick;
		start_test("conditions");
		for (int i = 0; i < RAND_ROUNDS; i++) begin
			// six one-hot types plus no branch
			pick      = {$random(seed)} % 7;
			exe_pc    = ({$random(seed)} % 2 == 0) ? PC_W'(512) : PC_W'(341);
			exe_btype = (pick == 6) ? '0 : BTYPE_W'(1) << pick;
			exe_z     = 1'($random(seed));
			exe_less  = 1'($random(seed));
			step();
		end
		exe_btype = '0;
		finish_test();
	endtask

	task automatic test_fifo_isr();
		logic [PC_W-1:0] pcs [5];
		start_test("fifo_isr");
		// five tags in set 7
		for (int k = 0; k < 5; k++)
			pcs[k] = {6'(50 + k), 4'h7};
		id_is_jump = 1'b1;
		for (int k = 0; k < 5; k++) begin
			id_pc            = pcs[k];
			id_branch_target = PC_W'(20 + k);
			step();
		end
		id_pc = pcs[0];
		step();
		compare_bit("evicted jump in table", 1'b0, seen_jib);
		id_pc = pcs[4];
		step();
		compare_bit("kept jump in table", 1'b1, seen_jib);
		// same pc from isr code uses another tag
		isr_running = 1'b1;
		step();
		compare_bit("jump seen from isr", 1'b0, seen_jib);
		isr_running = 1'b0;
		id_is_jump  = 1'b0;
		repeat (2) step();
		finish_test();
	endtask

	initial begin
		en               = 1'b1;
		stall            = 1'b0;
		isr_running      = 1'b0;
		id_pc            = '0;
		id_branch_target = '0;
		id_is_jump       = 1'b0;
		id_is_btype      = 1'b0;
		exe_pc           = '0;
		exe_z            = 1'b0;
		exe_less         = 1'b0;
		exe_btype        = '0;
		for (int i = 0; i < ENTRIES; i++) begin
			m_valid[i] = 1'b0;
			m_tag[i]   = '0;
			m_tgt[i]   = '0;
			m_ctr[i]   = '0;
		end
		for (int s = 0; s < NUM_SETS; s++)
			m_ptr[s] = '0;
		m_fstate = 1'b0;
		exp_pc   = '0;
		wait (nrst === 1'b1);
		test_seq_fetch();
		test_jump();
		test_branch_train();
		test_conditions();
		test_fifo_isr();
		$display("%0d tests run, %0d failed, %0d check errors", tests, failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* compile.f */
common/bp_pkg.sv
predictor/bht_table.sv
predictor/branch_resolve.sv
predictor/flush_ctrl.sv
verilog/next_pc_sel.sv
verilog/branch_unit_top.sv
test/tb_clock.sv
test/tb_branch_unit.sv
